// File: sim.f
+incdir+src
src/i2c_pkg.sv
src/i2c_cmd_queue.sv
src/i2c_bit_engine.sv
src/i2c_line_io.sv
src/i2c_write_top.sv
tb/i2c_write_sva.sv
tb/i2c_write_tb.sv

// File: Makefile
TOP := i2c_write_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

// File: tb/i2c_write_tb.sv
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_write_tb;
	import i2c_pkg::*;

	localparam logic [6:0] SLAVE_DEV = 7'h3c;
	localparam int TXN_CLKS = 1000; // clocks allowed per transaction

	logic        clk;
	logic        rstn;
	logic        req_valid;
	i2c_req_t    req;
	logic        sda_in;
	logic        scl;
	logic        sda_pull;
	logic        busy;
	logic        done;
	i2c_result_t result;
	logic        overrun;
	logic        slave_pull;

	logic [31:0] lfsr;
	int          err_cnt;
	int          chk_cnt;
	int          test_cnt;
	int          done_count;
	int          overrun_cnt;
	bit          aborted;
	i2c_result_t exp_q[$]; // accepted requests with predicted status

	int          starts;
	int          stops;
	logic [7:0]  rx_bytes[$];
	int          rx_counts[$]; // bytes seen per start/stop pair
	logic        prev_scl;
	logic        prev_sda;
	logic [7:0]  rx_shift;
	int          bit_cnt;
	int          rx_in_txn;
	logic        byte_done;
	logic        ack_due;
	logic        in_ack;

	assign sda_in = ~(sda_pull | slave_pull); // wired-AND line

	i2c_write_top dut_i (
		.clk      (clk),
		.rstn     (rstn),
		.req_valid(req_valid),
		.req      (req),
		.sda_in   (sda_in),
		.scl      (scl),
		.sda_pull (sda_pull),
		.busy     (busy),
		.done     (done),
		.result   (result),
		.overrun  (overrun)
	);

	bind i2c_write_top i2c_write_sva sva_i (
		.clk       (clk),
		.rstn      (rstn),
		.scl       (scl),
		.sda_pull  (sda_pull),
		.busy      (busy),
		.done      (done),
		.head_valid(head_valid),
		.state     (engine_state)
	);

	always #5 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// kind 0 acked write, 1 foreign device, 2 high register
	function automatic i2c_req_t make_req(input int kind);
		i2c_req_t r;
		r.dev      = (kind == 1) ? 7'(rand_bits(7)) : SLAVE_DEV;
		r.reg_addr = 8'(rand_bits(kind == 1 ? 8 : 7));
		r.data     = 8'(rand_bits(8));
		if (kind == 1 && r.dev == SLAVE_DEV)
			r.dev = r.dev ^ 7'h01;
		if (kind == 2)
			r.reg_addr = r.reg_addr | 8'h80;
		return r;
	endfunction

	// slave acks device 3c, registers below 80, any data
	function automatic logic slave_acks(input int idx, input logic [7:0] b);
		case (idx)
			0:       return (b[7:1] == SLAVE_DEV) && !b[0];
			1:       return b < 8'h80;
			default: return 1'b1;
		endcase
	endfunction

	function automatic i2c_status_e predict(input i2c_req_t r);
		if (r.dev != SLAVE_DEV)
			return ADDR_NACK;
		else if (r.reg_addr >= 8'h80)
			return REG_NACK;
		else
			return OK;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		chk_cnt++;
		if (exp !== got) begin
			$display("ERR %s exp %h got %h", name, exp, got);
			err_cnt++;
		end
	endtask

	task automatic expect_req(input i2c_req_t r);
		i2c_result_t e;
		e.req    = r;
		e.status = predict(r);
		exp_q.push_back(e);
	endtask

	task automatic issue(input i2c_req_t r);
		@(posedge clk);
		req_valid <= 1'b1;
		req       <= r;
	endtask

	task automatic idle_req();
		@(posedge clk);
		req_valid <= 1'b0;
	endtask

	// bytes the slave logged for the transaction that just finished
	task automatic check_bytes(input i2c_result_t r);
		logic [7:0] exp_b [3];
		logic [7:0] b;
		int         n_exp;
		int         n_got;
		exp_b[0] = {r.req.dev, 1'b0}; // write bit
		exp_b[1] = r.req.reg_addr;
		exp_b[2] = r.req.data;
		n_exp = (r.status == ADDR_NACK) ? 1 : (r.status == REG_NACK) ? 2 : 3;
		if (rx_counts.size() == 0) begin
			$display("no stop condition seen before done");
			err_cnt++;
		end else begin
			n_got = rx_counts.pop_front();
			check_val("rx_count", 32'(n_exp), 32'(n_got));
			for (int i = 0; i < n_got; i++) begin
				b = rx_bytes.pop_front();
				if (i < 3)
					check_val("rx_byte", 32'(exp_b[i]), 32'(b));
			end
		end
	endtask

	task automatic wait_done(input int target, input bit busy_held, input string what);
		int n;
		int limit;
		bit seen;
		limit = TXN_CLKS * (target - done_count);
		n = 0;
		seen = 1'b0;
		while (done_count < target && n < limit) begin
			@(posedge clk);
			n++;
			if (busy_held && done_count < target) begin
				if (seen)
					check_val("busy", 32'd1, 32'(busy)); // no gap between queued ones
				seen = seen | busy;
			end
		end
		if (done_count < target) begin
			$display("timeout: done never came for %s", what);
			err_cnt++;
			aborted = 1'b1;
		end
	endtask

	task automatic wait_busy(input string what);
		int n;
		n = 0;
		while (!busy && n < 100) begin
			@(posedge clk);
			n++;
		end
		if (!busy) begin
			$display("timeout: busy never rose for %s", what);
			err_cnt++;
			aborted = 1'b1;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		check_val("starts", 32'(done_count), 32'(starts));
		check_val("stops", 32'(done_count), 32'(stops));
		test_cnt++;
		$display("test %s: %s", name, (err_cnt == errs_before) ? "ok" : "errors");
	endtask

	task automatic single_writes(input int kind, input int n, input string name);
		int       errs;
		i2c_req_t r;
		errs = err_cnt;
		for (int i = 0; i < n && !aborted; i++) begin
			r = make_req(kind);
			expect_req(r);
			issue(r);
			idle_req();
			wait_done(done_count + 1, 1'b0, name);
		end
		finish_test(name, errs);
	endtask

	always @(posedge clk) begin : scoreboard
		i2c_result_t exp_r;
		if (rstn) begin
			if (overrun)
				overrun_cnt <= overrun_cnt + 1;
			if (done) begin
				if (exp_q.size() == 0) begin
					$display("done seen with no request outstanding");
					err_cnt++;
				end else begin
					exp_r = exp_q.pop_front();
					check_val("result.req", 32'(exp_r.req), 32'(result.req));
					check_val("result.status", 32'(exp_r.status), 32'(result.status));
					check_bytes(exp_r);
				end
				done_count <= done_count + 1;
			end
		end
	end

	// slave model finds edges against last cycle's line levels
	always @(posedge clk) begin : slave_model
		if (!rstn) begin
			prev_scl   = 1'b1;
			prev_sda   = 1'b1;
			bit_cnt    = 0;
			rx_in_txn  = 0;
			byte_done  = 1'b0;
			in_ack     = 1'b0;
			slave_pull <= 1'b0;
		end else begin
			if (prev_scl && scl && prev_sda && !sda_in) begin
				starts++; // start
				bit_cnt   = 0;
				rx_in_txn = 0;
				byte_done = 1'b0;
				in_ack    = 1'b0;
			end else if (prev_scl && scl && !prev_sda && sda_in) begin
				stops++; // stop
				rx_counts.push_back(rx_in_txn);
				in_ack     = 1'b0;
				slave_pull <= 1'b0;
			end else if (!prev_scl && scl && !in_ack) begin
				rx_shift = {rx_shift[6:0], sda_in};
				bit_cnt++;
				if (bit_cnt == `I2C_BYTE_BITS) begin
					rx_bytes.push_back(rx_shift);
					ack_due   = slave_acks(rx_in_txn, rx_shift);
					rx_in_txn++;
					bit_cnt   = 0;
					byte_done = 1'b1;
				end
			end else if (prev_scl && !scl) begin
				if (byte_done) begin
					slave_pull <= ack_due; // hold through the ninth clock
					in_ack    = 1'b1;
					byte_done = 1'b0;
				end else if (in_ack) begin
					slave_pull <= 1'b0;
					in_ack     = 1'b0;
				end
			end
			prev_scl = scl;
			prev_sda = sda_in;
		end
	end

	initial begin : main
		int       errs;
		int       target;
		int       occ;
		int       dropped;
		int       ovr_before;
		i2c_req_t r;
		clk        = 1'b0;
		rstn       = 1'b0;
		req_valid  = 1'b0;
		req        = '0;
		slave_pull = 1'b0;
		lfsr       = 32'ha2a3;
		aborted    = 1'b0;
		repeat (4) @(posedge clk);
		rstn <= 1'b1;

		errs = err_cnt;
		repeat (20) begin
			@(posedge clk);
			check_val("scl", 32'd1, 32'(scl));
			check_val("sda_pull", 32'd0, 32'(sda_pull));
			check_val("busy", 32'd0, 32'(busy));
			check_val("done", 32'd0, 32'(done));
		end
		finish_test("idle_after_reset", errs);

		single_writes(0, 4, "write_ok");
		if (!aborted)
			single_writes(1, 3, "addr_nack");
		if (!aborted)
			single_writes(2, 3, "reg_nack");

		if (!aborted) begin
			errs = err_cnt;
			target = done_count + 4;
			for (int i = 0; i < 4; i++) begin
				r = make_req(int'(rand_bits(2)) % 3);
				expect_req(r);
				issue(r);
			end
			idle_req();
			wait_done(target, 1'b1, "queued requests");
			finish_test("queue_order", errs);
		end

		if (!aborted) begin
			errs = err_cnt;
			r = make_req(0);
			expect_req(r);
			issue(r);
			idle_req();
			target = done_count + 1;
			wait_busy("transaction ahead of burst");
			occ = 0;
			dropped = 0;
			ovr_before = overrun_cnt;
			for (int i = 0; i < 6; i++) begin
				r = make_req(int'(rand_bits(2)) % 3);
				if (occ < `I2C_QUEUE_DEPTH) begin
					expect_req(r);
					occ++;
				end else begin
					dropped++;
				end
				issue(r);
			end
			idle_req();
			wait_done(target + occ, 1'b0, "accepted burst");
			repeat (TXN_CLKS) @(posedge clk); // dropped ones must stay silent
			check_val("overrun_pulses", 32'(dropped), 32'(overrun_cnt - ovr_before));
			check_val("pending", 32'd0, 32'(exp_q.size()));
			finish_test("overrun", errs);
		end

		$display("tests %0d checks %0d errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: tb/i2c_write_sva.sv
`timescale 1ns/1ps

module i2c_write_sva (
	input logic                clk,
	input logic                rstn,
	input logic                scl,
	input logic                sda_pull,
	input logic                busy,
	input logic                done,
	input logic                head_valid,
	input i2c_pkg::i2c_state_e state
);
	import i2c_pkg::*;

	// single-cycle strobe
	done_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
		done |=> !done)
		else $error("done held longer than one cycle");

	// nothing waiting and engine idle, so busy drops
	busy_clears: assert property (@(posedge clk) disable iff (!rstn)
		done && !head_valid && state == IDLE |=> !busy)
		else $error("busy still high after done with empty queue");

	idle_lines: assert property (@(posedge clk) disable iff (!rstn)
		state == IDLE |-> scl && !sda_pull)
		else $error("bus not released while engine idle");

endmodule

// File: src/i2c_write_top.sv
`timescale 1ns/1ps

module i2c_write_top (
	input  logic                clk,
	input  logic                rstn,
	input  logic                req_valid,
	input  i2c_pkg::i2c_req_t    req,
	input  logic                sda_in,
	output logic                scl,
	output logic                sda_pull,
	output logic                busy,
	output logic                done,
	output i2c_pkg::i2c_result_t result,
	output logic                overrun
);
	import i2c_pkg::*;

	i2c_req_t    head;
	logic        head_valid;
	logic        pop;
	logic        sda_sync;
	logic        scl_out;
	logic        sda_low;
	logic        fin;
	i2c_result_t fin_result;
	i2c_state_e  engine_state; // observed by the bound checks

	i2c_cmd_queue queue_i (
		.clk       (clk),
		.rstn      (rstn),
		.req_valid (req_valid),
		.req       (req),
		.pop       (pop),
		.head      (head),
		.head_valid(head_valid),
		.overrun   (overrun)
	);

	i2c_bit_engine engine_i (
		.clk       (clk),
		.rstn      (rstn),
		.head      (head),
		.head_valid(head_valid),
		.pop       (pop),
		.sda_sync  (sda_sync),
		.scl_out   (scl_out),
		.sda_low   (sda_low),
		.fin       (fin),
		.fin_result(fin_result),
		.state     (engine_state)
	);

	i2c_line_io line_i (
		.clk       (clk),
		.rstn      (rstn),
		.scl_out   (scl_out),
		.sda_low   (sda_low),
		.sda_in    (sda_in),
		.pop       (pop),
		.fin       (fin),
		.fin_result(fin_result),
		.sda_sync  (sda_sync),
		.scl       (scl),
		.sda_pull  (sda_pull),
		.busy      (busy),
		.done      (done),
		.result    (result)
	);

endmodule

// File: src/i2c_line_io.sv
`timescale 1ns/1ps

module i2c_line_io (
	input  logic                clk,
	input  logic                rstn,
	input  logic                scl_out,
	input  logic                sda_low,
	input  logic                sda_in,
	input  logic                pop,
	input  logic                fin,
	input  i2c_pkg::i2c_result_t fin_result,
	output logic                sda_sync,
	output logic                scl,
	output logic                sda_pull,
	output logic                busy,
	output logic                done,
	output i2c_pkg::i2c_result_t result
);

	logic sda_meta;

	// open-drain drives, already registered in the engine
	assign scl      = scl_out;
	assign sda_pull = sda_low;

	// two-flop synchronizer, idle line reads high
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			sda_meta <= 1'b1;
			sda_sync <= 1'b1;
		end else begin
			sda_meta <= sda_in;
			sda_sync <= sda_meta;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			done <= 1'b0;
			busy <= 1'b0;
		end else begin
			done <= fin;
			if (pop)
				busy <= 1'b1; // back-to-back pop wins over done
			else if (done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fin)
			result <= fin_result;
	end

endmodule

// File: src/i2c_bit_engine.sv
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_bit_engine (
	input  logic                clk,
	input  logic                rstn,
	input  i2c_pkg::i2c_req_t    head,
	input  logic                head_valid,
	output logic                pop,
	input  logic                sda_sync,
	output logic                scl_out,
	output logic                sda_low,
	output logic                fin,
	output i2c_pkg::i2c_result_t fin_result,
	output i2c_pkg::i2c_state_e  state
);
	import i2c_pkg::*;

	localparam int QUARTER = `I2C_QUARTER_CLKS;
	localparam int BITS    = `I2C_BYTE_BITS;
	localparam int QW      = $clog2(QUARTER);
	localparam int BW      = $clog2(BITS);

	logic [QW-1:0]   qcnt;     // clocks within a quarter
	logic [1:0]      quarter;  // quarter within a bit period
	logic [BW-1:0]   bit_cnt;
	logic [1:0]      byte_idx; // 0 addr, 1 reg, 2 data
	logic [BITS-1:0] shreg;
	logic [BITS-1:0] next_byte;
	i2c_req_t        cur;
	i2c_status_e     status;
	i2c_status_e     nack_status;
	logic            nack;
	logic            q_end;
	logic            bit_end;
	logic            start_tx;

	assign q_end    = (qcnt == QW'(QUARTER - 1));
	assign bit_end  = q_end && (quarter == 2'd3);
	assign start_tx = (state == IDLE) && head_valid;

	// byte following the one just acknowledged
	always_comb begin
		case (byte_idx)
			2'd0:    next_byte = cur.reg_addr;
			default: next_byte = cur.data;
		endcase
	end

	always_comb begin
		case (byte_idx)
			2'd0:    nack_status = ADDR_NACK;
			2'd1:    nack_status = REG_NACK;
			default: nack_status = DATA_NACK;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state    <= IDLE;
			qcnt     <= '0;
			quarter  <= '0;
			bit_cnt  <= '0;
			byte_idx <= '0;
			status   <= OK;
			nack     <= 1'b0;
			scl_out  <= 1'b1;
			sda_low  <= 1'b0;
			pop      <= 1'b0;
			fin      <= 1'b0;
		end else begin
			pop <= 1'b0;
			fin <= 1'b0;
			if (state != IDLE) begin
				qcnt <= q_end ? '0 : qcnt + 1'b1;
				if (q_end)
					quarter <= quarter + 1'b1;
			end
			case (state)
				IDLE: begin
					if (head_valid) begin
						state    <= START;
						pop      <= 1'b1;
						sda_low  <= 1'b1; // sda falls while scl high
						qcnt     <= '0;
						quarter  <= '0;
						byte_idx <= '0;
					end
				end
				START: begin
					if (q_end && quarter == 2'd1) begin
						state   <= SEND_BIT;
						quarter <= '0;
						scl_out <= 1'b0;
						sda_low <= ~shreg[BITS-1];
						bit_cnt <= BW'(BITS - 1);
					end
				end
				SEND_BIT: begin
					if (q_end) begin
						case (quarter)
							2'd1: scl_out <= 1'b1;
							2'd3: begin
								scl_out <= 1'b0;
								if (bit_cnt == '0) begin
									state   <= ACK_SLOT;
									sda_low <= 1'b0; // let the slave drive
								end else begin
									bit_cnt <= bit_cnt - 1'b1;
									sda_low <= ~shreg[BITS-2];
								end
							end
							default: ;
						endcase
					end
				end
				ACK_SLOT: begin
					if (q_end) begin
						case (quarter)
							2'd1: scl_out <= 1'b1;
							2'd2: nack <= sda_sync; // high means no ack
							2'd3: begin
								scl_out <= 1'b0;
								if (nack) begin
									state   <= STOP;
									sda_low <= 1'b1;
									status  <= nack_status;
								end else if (byte_idx == 2'd2) begin
									state   <= STOP;
									sda_low <= 1'b1;
									status  <= OK;
								end else begin
									state    <= SEND_BIT;
									byte_idx <= byte_idx + 1'b1;
									bit_cnt  <= BW'(BITS - 1);
									sda_low  <= ~next_byte[BITS-1];
								end
							end
							default: ;
						endcase
					end
				end
				STOP: begin
					if (q_end) begin
						case (quarter)
							2'd0: scl_out <= 1'b1;
							2'd1: sda_low <= 1'b0; // sda rises with scl high
							2'd2: begin
								state   <= GAP;
								quarter <= '0;
							end
							default: ;
						endcase
					end
				end
				GAP: begin
					if (q_end) begin
						state <= IDLE;
						fin   <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (start_tx) begin
			cur   <= head;
			shreg <= {head.dev, 1'b0}; // write bit is 0
		end else if (state == SEND_BIT && bit_end && bit_cnt != '0) begin
			shreg <= shreg << 1;
		end else if (state == ACK_SLOT && bit_end) begin
			shreg <= next_byte;
		end
		if (state == GAP && q_end) begin
			fin_result.req    <= cur;
			fin_result.status <= status;
		end
	end

endmodule

// File: src/i2c_cmd_queue.sv
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_cmd_queue (
	input  logic             clk,
	input  logic             rstn,
	input  logic             req_valid,
	input  i2c_pkg::i2c_req_t req,
	input  logic             pop,
	output i2c_pkg::i2c_req_t head,
	output logic             head_valid,
	output logic             overrun
);
	import i2c_pkg::*;

	localparam int DEPTH = `I2C_QUEUE_DEPTH;
	localparam int PW    = $clog2(DEPTH);
	localparam int CW    = $clog2(DEPTH + 1);

	i2c_req_t mem [DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          full;
	logic          do_pop;
	logic          do_push;

	assign full    = (count == CW'(DEPTH));
	assign do_pop  = pop && head_valid;
	// a pop in the same cycle frees the slot
	assign do_push = req_valid && (!full || do_pop);

	assign head       = mem[rd_ptr];
	assign head_valid = (count != '0);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			overrun <= 1'b0;
		end else begin
			overrun <= req_valid && !do_push; // request dropped
			if (do_push)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage, no reset
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= req;
	end

endmodule

// File: src/i2c_pkg.sv
`include "i2c_consts.svh"

package i2c_pkg;

	// one register write: device, register, data
	typedef struct packed {
		logic [`I2C_BYTE_BITS-2:0] dev;      // 7-bit address, r/w bit added on the wire
		logic [`I2C_BYTE_BITS-1:0] reg_addr;
		logic [`I2C_BYTE_BITS-1:0] data;
	} i2c_req_t;

	// outcome of one transaction
	typedef enum logic [1:0] {
		OK,
		ADDR_NACK,
		REG_NACK,
		DATA_NACK
	} i2c_status_e;

	typedef struct packed {
		i2c_req_t    req;
		i2c_status_e status;
	} i2c_result_t;

	// bit engine states
	typedef enum logic [3:0] {
		IDLE,
		START,
		SEND_BIT,
		ACK_SLOT,
		STOP,
		GAP
	} i2c_state_e;

endpackage

// File: src/i2c_consts.svh
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

// command queue entries
`define I2C_QUEUE_DEPTH 4

// system clocks per quarter of an scl period
`define I2C_QUARTER_CLKS 4

// bits per byte on the wire
`define I2C_BYTE_BITS 8

`endif
